/* hw/nx_pkg.sv */
package nx_pkg;

    // Neighbour directions, numbered clockwise from north
    typedef enum logic [1:0] {
        NX_DIR_NORTH = 2'd0,
        NX_DIR_EAST  = 2'd1,
        NX_DIR_SOUTH = 2'd2,
        NX_DIR_WEST  = 2'd3
    } nx_dir_t;

    // Width of a row or column index
    localparam int NX_ID_WIDTH = 4;

    // Header bits at the top of every message
    localparam int NX_HDR_WIDTH = 9;

    // Header field positions, as offsets below the message MSB
    // Broadcast flag
    localparam int NX_BCAST_OFS = 0;
    // Target row, NX_ID_WIDTH bits
    localparam int NX_ROW_OFS = 1;
    // Target column, NX_ID_WIDTH bits
    // For a broadcast the top two column bits carry the forward direction
    localparam int NX_COL_OFS = 5;

endpackage : nx_pkg

/* hw/nx_stream_skid.sv */
module nx_stream_skid #(
      parameter type payload_t = logic [31:0]
) (
      input  logic     clk_i
    , input  logic     rst_n_i
    // Inbound stream
    , input  payload_t in_data_i
    , input  logic     in_valid_i
    , output logic     in_ready_o
    // Outbound stream
    , output payload_t out_data_o
    , output logic     out_valid_o
    , input  logic     out_ready_i
);

// Main register drives the output, skid register catches a stalled beat
payload_t main_q, skid_q;
logic     main_valid_q, skid_valid_q, ready_q;
logic     main_valid_d, skid_valid_d;
logic     in_fire, out_fire;
logic     load_main, load_skid;

assign in_fire  = in_valid_i && ready_q;
assign out_fire = main_valid_q && out_ready_i;

// Beat arrives while the main register is stuck
assign load_skid = in_fire && main_valid_q && !out_ready_i;

// Refill from skid first to keep order
assign load_main = skid_valid_q ? out_fire : (in_fire && (!main_valid_q || out_ready_i));

always_comb begin
    if (skid_valid_q) begin
        main_valid_d = 1'b1;
        skid_valid_d = !out_fire;
    end else begin
        main_valid_d = (main_valid_q && !out_ready_i) || in_fire;
        skid_valid_d = load_skid;
    end
end

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        main_valid_q <= 1'b0;
        skid_valid_q <= 1'b0;
        ready_q      <= 1'b0;
    end else begin
        main_valid_q <= main_valid_d;
        skid_valid_q <= skid_valid_d;
        // Ready means the skid register will be empty
        ready_q      <= !skid_valid_d;
    end
end

always_ff @(posedge clk_i) begin
    if (load_main) begin
        main_q <= skid_valid_q ? skid_q : in_data_i;
    end
    if (load_skid) begin
        skid_q <= in_data_i;
    end
end

assign in_ready_o  = ready_q;
assign out_data_o  = main_q;
assign out_valid_o = main_valid_q;

endmodule : nx_stream_skid

/* hw/nx_msg_decoder.sv */
module nx_msg_decoder #(
      parameter int STREAM_WIDTH = 32
) (
      input  logic                               clk_i
    , input  logic                               rst_n_i
    // Position of this node in the mesh
    , input  logic [nx_pkg::NX_ID_WIDTH-1:0]     node_row_i
    , input  logic [nx_pkg::NX_ID_WIDTH-1:0]     node_col_i
    // Inbound message stream
    , input  logic [STREAM_WIDTH-1:0]            in_data_i
    , input  logic                               in_valid_i
    , output logic                               in_ready_o
    // Local delivery
    , output logic [STREAM_WIDTH-1:0]            local_data_o
    , output logic                               local_valid_o
    , input  logic                               local_ready_i
    // Forward path toward the distributor
    , output logic [STREAM_WIDTH-1:0]            fwd_data_o
    , output nx_pkg::nx_dir_t                    fwd_dir_o
    , output logic                               fwd_valid_o
    , input  logic                               fwd_ready_i
);

localparam int ID_W = nx_pkg::NX_ID_WIDTH;

// Message must hold the full header plus at least one payload bit
if (STREAM_WIDTH < nx_pkg::NX_HDR_WIDTH + 1) begin : g_width_check
    $error("STREAM_WIDTH too small for the message header");
end

typedef struct packed {
    logic [STREAM_WIDTH-1:0] data;
    nx_pkg::nx_dir_t         dir;
    logic                    is_local;
    logic                    is_fwd;
} dec_msg_t;

logic            bcast;
logic [ID_W-1:0] tgt_row, tgt_col;
dec_msg_t        dec_in, dec_out;
logic            dec_valid, dec_ready;
logic            local_done_q, fwd_done_q;
logic            local_ok, fwd_ok;

// Header fields
assign bcast   = in_data_i[STREAM_WIDTH-1-nx_pkg::NX_BCAST_OFS];
assign tgt_row = in_data_i[STREAM_WIDTH-1-nx_pkg::NX_ROW_OFS -: ID_W];
assign tgt_col = in_data_i[STREAM_WIDTH-1-nx_pkg::NX_COL_OFS -: ID_W];

// XY routing, column resolved before row
always_comb begin
    dec_in.data     = in_data_i;
    dec_in.dir      = nx_pkg::NX_DIR_NORTH;
    dec_in.is_local = 1'b0;
    dec_in.is_fwd   = 1'b1;
    if (bcast) begin
        dec_in.dir      = nx_pkg::nx_dir_t'(tgt_col[ID_W-1 -: 2]);
        dec_in.is_local = 1'b1;
    end else if (tgt_col != node_col_i) begin
        dec_in.dir = (tgt_col > node_col_i) ? nx_pkg::NX_DIR_EAST : nx_pkg::NX_DIR_WEST;
    end else if (tgt_row != node_row_i) begin
        dec_in.dir = (tgt_row > node_row_i) ? nx_pkg::NX_DIR_SOUTH : nx_pkg::NX_DIR_NORTH;
    end else begin
        // Addressed to us
        dec_in.is_local = 1'b1;
        dec_in.is_fwd   = 1'b0;
    end
end

nx_stream_skid #(
      .payload_t(dec_msg_t)
) u_dec_skid (
      .clk_i      (clk_i)
    , .rst_n_i    (rst_n_i)
    , .in_data_i  (dec_in)
    , .in_valid_i (in_valid_i)
    , .in_ready_o (in_ready_o)
    , .out_data_o (dec_out)
    , .out_valid_o(dec_valid)
    , .out_ready_i(dec_ready)
);

// Fork, the record retires once every path it needs has taken it
assign local_ok  = !dec_out.is_local || local_done_q || local_ready_i;
assign fwd_ok    = !dec_out.is_fwd || fwd_done_q || fwd_ready_i;
assign dec_ready = local_ok && fwd_ok;

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        local_done_q <= 1'b0;
        fwd_done_q   <= 1'b0;
    end else if (dec_valid && dec_ready) begin
        local_done_q <= 1'b0;
        fwd_done_q   <= 1'b0;
    end else begin
        if (local_valid_o && local_ready_i) local_done_q <= 1'b1;
        if (fwd_valid_o && fwd_ready_i) fwd_done_q <= 1'b1;
    end
end

assign local_data_o  = dec_out.data;
assign local_valid_o = dec_valid && dec_out.is_local && !local_done_q;
assign fwd_data_o    = dec_out.data;
assign fwd_dir_o     = dec_out.dir;
assign fwd_valid_o   = dec_valid && dec_out.is_fwd && !fwd_done_q;

endmodule : nx_msg_decoder

/* hw/nx_stream_distributor.sv */
module nx_stream_distributor #(
      parameter int STREAM_WIDTH = 32
    , parameter bit OUT_SKID     = 1'b1
) (
      input  logic                    clk_i
    , input  logic                    rst_n_i
    // Decoded message stream
    , input  logic [STREAM_WIDTH-1:0] dist_data_i
    , input  nx_pkg::nx_dir_t         dist_dir_i
    , input  logic                    dist_valid_i
    , output logic                    dist_ready_o
    // North
    , output logic [STREAM_WIDTH-1:0] north_data_o
    , output logic                    north_valid_o
    , input  logic                    north_ready_i
    , input  logic                    north_present_i
    // East
    , output logic [STREAM_WIDTH-1:0] east_data_o
    , output logic                    east_valid_o
    , input  logic                    east_ready_i
    , input  logic                    east_present_i
    // South
    , output logic [STREAM_WIDTH-1:0] south_data_o
    , output logic                    south_valid_o
    , input  logic                    south_ready_i
    , input  logic                    south_present_i
    // West
    , output logic [STREAM_WIDTH-1:0] west_data_o
    , output logic                    west_valid_o
    , input  logic                    west_ready_i
    , input  logic                    west_present_i
);

typedef logic [STREAM_WIDTH-1:0] msg_t;

logic       bcast;
logic [1:0] tgt_idx, cw_idx;
logic [3:0] present;
logic [3:0] route_valid, route_ready;
logic [3:0] out_valid, out_ready;
msg_t       out_data [4];

assign bcast = dist_data_i[STREAM_WIDTH-1-nx_pkg::NX_BCAST_OFS];

// Vectors indexed by direction encoding
assign present   = {west_present_i, south_present_i, east_present_i, north_present_i};
assign out_ready = {west_ready_i, south_ready_i, east_ready_i, north_ready_i};

// Clockwise neighbour is the next encoding, wrapping west to north
assign tgt_idx = dist_dir_i;
assign cw_idx  = tgt_idx + 2'd1;

// Absent target: unicast detours clockwise, broadcast is dropped
always_comb begin
    route_valid = '0;
    if (present[tgt_idx]) begin
        route_valid[tgt_idx] = dist_valid_i;
    end else if (!bcast) begin
        route_valid[cw_idx] = dist_valid_i;
    end
end

// Dropped broadcast is swallowed right away
assign dist_ready_o = present[tgt_idx] ? route_ready[tgt_idx]
                                       : (bcast || route_ready[cw_idx]);

for (genvar d = 0; d < 4; d++) begin : g_out
    if (OUT_SKID) begin : g_skid
        nx_stream_skid #(
              .payload_t(msg_t)
        ) u_skid (
              .clk_i      (clk_i)
            , .rst_n_i    (rst_n_i)
            , .in_data_i  (dist_data_i)
            , .in_valid_i (route_valid[d])
            , .in_ready_o (route_ready[d])
            , .out_data_o (out_data[d])
            , .out_valid_o(out_valid[d])
            , .out_ready_i(out_ready[d])
        );
    end else begin : g_pass
        // Combinational path, no storage
        assign out_data[d]    = dist_data_i;
        assign out_valid[d]   = route_valid[d];
        assign route_ready[d] = out_ready[d];
    end
end

assign north_data_o  = out_data[nx_pkg::NX_DIR_NORTH];
assign north_valid_o = out_valid[nx_pkg::NX_DIR_NORTH];

assign east_data_o   = out_data[nx_pkg::NX_DIR_EAST];
assign east_valid_o  = out_valid[nx_pkg::NX_DIR_EAST];

assign south_data_o  = out_data[nx_pkg::NX_DIR_SOUTH];
assign south_valid_o = out_valid[nx_pkg::NX_DIR_SOUTH];

assign west_data_o   = out_data[nx_pkg::NX_DIR_WEST];
assign west_valid_o  = out_valid[nx_pkg::NX_DIR_WEST];

endmodule : nx_stream_distributor

/* hw/nx_node_router.sv */
module nx_node_router #(
      parameter int STREAM_WIDTH = 32
    , parameter bit OUT_SKID     = 1'b1
) (
      input  logic                           clk_i
    , input  logic                           rst_n_i
    // Mesh position
    , input  logic [nx_pkg::NX_ID_WIDTH-1:0] node_row_i
    , input  logic [nx_pkg::NX_ID_WIDTH-1:0] node_col_i
    // Inbound messages
    , input  logic [STREAM_WIDTH-1:0]        in_data_i
    , input  logic                           in_valid_i
    , output logic                           in_ready_o
    // Messages for this node
    , output logic [STREAM_WIDTH-1:0]        local_data_o
    , output logic                           local_valid_o
    , input  logic                           local_ready_i
    // North
    , output logic [STREAM_WIDTH-1:0]        north_data_o
    , output logic                           north_valid_o
    , input  logic                           north_ready_i
    , input  logic                           north_present_i
    // East
    , output logic [STREAM_WIDTH-1:0]        east_data_o
    , output logic                           east_valid_o
    , input  logic                           east_ready_i
    , input  logic                           east_present_i
    // South
    , output logic [STREAM_WIDTH-1:0]        south_data_o
    , output logic                           south_valid_o
    , input  logic                           south_ready_i
    , input  logic                           south_present_i
    // West
    , output logic [STREAM_WIDTH-1:0]        west_data_o
    , output logic                           west_valid_o
    , input  logic                           west_ready_i
    , input  logic                           west_present_i
);

// Decoder to distributor
logic [STREAM_WIDTH-1:0] fwd_data;
nx_pkg::nx_dir_t         fwd_dir;
logic                    fwd_valid;
logic                    fwd_ready;

nx_msg_decoder #(
      .STREAM_WIDTH(STREAM_WIDTH)
) u_decoder (
      .clk_i        (clk_i)
    , .rst_n_i      (rst_n_i)
    , .node_row_i   (node_row_i)
    , .node_col_i   (node_col_i)
    , .in_data_i    (in_data_i)
    , .in_valid_i   (in_valid_i)
    , .in_ready_o   (in_ready_o)
    , .local_data_o (local_data_o)
    , .local_valid_o(local_valid_o)
    , .local_ready_i(local_ready_i)
    , .fwd_data_o   (fwd_data)
    , .fwd_dir_o    (fwd_dir)
    , .fwd_valid_o  (fwd_valid)
    , .fwd_ready_i  (fwd_ready)
);

nx_stream_distributor #(
      .STREAM_WIDTH(STREAM_WIDTH)
    , .OUT_SKID    (OUT_SKID)
) u_distributor (
      .clk_i          (clk_i)
    , .rst_n_i        (rst_n_i)
    , .dist_data_i    (fwd_data)
    , .dist_dir_i     (fwd_dir)
    , .dist_valid_i   (fwd_valid)
    , .dist_ready_o   (fwd_ready)
    , .north_data_o   (north_data_o)
    , .north_valid_o  (north_valid_o)
    , .north_ready_i  (north_ready_i)
    , .north_present_i(north_present_i)
    , .east_data_o    (east_data_o)
    , .east_valid_o   (east_valid_o)
    , .east_ready_i   (east_ready_i)
    , .east_present_i (east_present_i)
    , .south_data_o   (south_data_o)
    , .south_valid_o  (south_valid_o)
    , .south_ready_i  (south_ready_i)
    , .south_present_i(south_present_i)
    , .west_data_o    (west_data_o)
    , .west_valid_o   (west_valid_o)
    , .west_ready_i   (west_ready_i)
    , .west_present_i (west_present_i)
);

endmodule : nx_node_router

/* sim/nx_router_properties.sv */
module nx_router_properties #(
      parameter int STREAM_WIDTH = 32
) (
      input logic                    clk_i
    , input logic                    rst_n_i
    , input logic                    local_valid_i
    , input logic                    local_ready_i
    , input logic [STREAM_WIDTH-1:0] local_data_i
    , input logic                    north_valid_i
    , input logic                    north_ready_i
    , input logic [STREAM_WIDTH-1:0] north_data_i
    , input logic                    east_valid_i
    , input logic                    east_ready_i
    , input logic [STREAM_WIDTH-1:0] east_data_i
    , input logic                    south_valid_i
    , input logic                    south_ready_i
    , input logic [STREAM_WIDTH-1:0] south_data_i
    , input logic                    west_valid_i
    , input logic                    west_ready_i
    , input logic [STREAM_WIDTH-1:0] west_data_i
);

int assert_fails = 0;

// A stalled beat keeps valid and data until it is taken
property hold_while_stalled(logic valid, logic ready, logic [STREAM_WIDTH-1:0] data);
    @(posedge clk_i) disable iff (!rst_n_i)
        valid && !ready |=> valid && $stable(data);
endproperty

assert property (hold_while_stalled(local_valid_i, local_ready_i, local_data_i))
    else begin
        $error("local stream changed while stalled");
        assert_fails++;
    end
assert property (hold_while_stalled(north_valid_i, north_ready_i, north_data_i))
    else begin
        $error("north stream changed while stalled");
        assert_fails++;
    end
assert property (hold_while_stalled(east_valid_i, east_ready_i, east_data_i))
    else begin
        $error("east stream changed while stalled");
        assert_fails++;
    end
assert property (hold_while_stalled(south_valid_i, south_ready_i, south_data_i))
    else begin
        $error("south stream changed while stalled");
        assert_fails++;
    end
assert property (hold_while_stalled(west_valid_i, west_ready_i, west_data_i))
    else begin
        $error("west stream changed while stalled");
        assert_fails++;
    end

// Sync reset, so outputs are cleared one edge after reset is seen
assert property (@(posedge clk_i) !rst_n_i |=> !local_valid_i && !north_valid_i
                 && !east_valid_i && !south_valid_i && !west_valid_i)
    else begin
        $error("valid output high during reset");
        assert_fails++;
    end

// One message enters the distributor per cycle
assert property (@(posedge clk_i) disable iff (!rst_n_i)
                 $onehot0({$rose(north_valid_i), $rose(east_valid_i),
                           $rose(south_valid_i), $rose(west_valid_i)}))
    else begin
        $error("more than one neighbour valid rose in one cycle");
        assert_fails++;
    end

endmodule : nx_router_properties

bind nx_node_router nx_router_properties #(
      .STREAM_WIDTH(STREAM_WIDTH)
) u_props (
      .clk_i        (clk_i)
    , .rst_n_i      (rst_n_i)
    , .local_valid_i(local_valid_o)
    , .local_ready_i(local_ready_i)
    , .local_data_i (local_data_o)
    , .north_valid_i(north_valid_o)
    , .north_ready_i(north_ready_i)
    , .north_data_i (north_data_o)
    , .east_valid_i (east_valid_o)
    , .east_ready_i (east_ready_i)
    , .east_data_i  (east_data_o)
    , .south_valid_i(south_valid_o)
    , .south_ready_i(south_ready_i)
    , .south_data_i (south_data_o)
    , .west_valid_i (west_valid_o)
    , .west_ready_i (west_ready_i)
    , .west_data_i  (west_data_o)
);

/* sim/tb_nx_node_router.sv */
module tb_nx_node_router;

localparam int         TIMEOUT    = 100;
localparam logic [3:0] NODE_ROW   = 4'd5;
localparam logic [3:0] NODE_COL   = 4'd5;
// Output port codes beyond the four neighbour directions
localparam logic [2:0] PORT_LOCAL = 3'd4;
localparam logic [2:0] PORT_NONE  = 3'd7;

logic        clk_i;
logic        rst_n_i;
logic [31:0] in_data_i;
logic        in_valid_i;
logic        in_ready_o;
logic [31:0] local_data_o;
logic        local_valid_o;
logic        local_ready_i;
logic [31:0] north_data_o, east_data_o, south_data_o, west_data_o;
logic        north_valid_o, east_valid_o, south_valid_o, west_valid_o;
// Indexed by direction encoding
logic [3:0]  nb_ready;
logic [3:0]  present;

integer      seed = 32'ha11e;
int          errors = 0;
int          timeouts = 0;
// Every transfer seen on an output, as {port, data}
logic [34:0] seen_q [$];

nx_node_router #(
      .STREAM_WIDTH(32)
    , .OUT_SKID    (1'b1)
) UUT (
      .clk_i(clk_i), .rst_n_i(rst_n_i)
    , .node_row_i(NODE_ROW), .node_col_i(NODE_COL)
    , .in_data_i(in_data_i), .in_valid_i(in_valid_i), .in_ready_o(in_ready_o)
    , .local_data_o(local_data_o), .local_valid_o(local_valid_o)
    , .local_ready_i(local_ready_i)
    , .north_data_o(north_data_o), .north_valid_o(north_valid_o)
    , .north_ready_i(nb_ready[0]), .north_present_i(present[0])
    , .east_data_o(east_data_o), .east_valid_o(east_valid_o)
    , .east_ready_i(nb_ready[1]), .east_present_i(present[1])
    , .south_data_o(south_data_o), .south_valid_o(south_valid_o)
    , .south_ready_i(nb_ready[2]), .south_present_i(present[2])
    , .west_data_o(west_data_o), .west_valid_o(west_valid_o)
    , .west_ready_i(nb_ready[3]), .west_present_i(present[3])
);

initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
end

// Output monitor
always @(posedge clk_i) begin
    if (rst_n_i) begin
        if (local_valid_o && local_ready_i) seen_q.push_back({PORT_LOCAL, local_data_o});
        if (north_valid_o && nb_ready[0]) seen_q.push_back({3'd0, north_data_o});
        if (east_valid_o && nb_ready[1]) seen_q.push_back({3'd1, east_data_o});
        if (south_valid_o && nb_ready[2]) seen_q.push_back({3'd2, south_data_o});
        if (west_valid_o && nb_ready[3]) seen_q.push_back({3'd3, west_data_o});
    end
end

task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        $display("ERR @%0t: %s, got %h expected %h", $time, what, got, exp);
        errors++;
    end
endtask

function automatic logic [31:0] make_msg(input logic bc, input logic [3:0] row,
                                         input logic [3:0] col, input logic [31:0] payload);
    return {bc, row, col, payload[22:0]};
endfunction

// Expected local delivery for a broadcast or a message addressed here
function automatic logic ref_is_local(input logic [31:0] msg);
    logic [3:0] row;
    logic [3:0] col;
    row = msg[31-nx_pkg::NX_ROW_OFS -: 4];
    col = msg[31-nx_pkg::NX_COL_OFS -: 4];
    return msg[31-nx_pkg::NX_BCAST_OFS] || (row == NODE_ROW && col == NODE_COL);
endfunction

// Expected neighbour port after XY routing, reroute and drop
function automatic logic [2:0] ref_fwd_port(input logic [31:0] msg, input logic [3:0] avail);
    logic       bc;
    logic [3:0] row;
    logic [3:0] col;
    logic [1:0] dir;
    bc  = msg[31-nx_pkg::NX_BCAST_OFS];
    row = msg[31-nx_pkg::NX_ROW_OFS -: 4];
    col = msg[31-nx_pkg::NX_COL_OFS -: 4];
    if (bc) begin
        dir = col[3:2];
    end else if (col > NODE_COL) begin
        dir = nx_pkg::NX_DIR_EAST;
    end else if (col < NODE_COL) begin
        dir = nx_pkg::NX_DIR_WEST;
    end else if (row > NODE_ROW) begin
        dir = nx_pkg::NX_DIR_SOUTH;
    end else if (row < NODE_ROW) begin
        dir = nx_pkg::NX_DIR_NORTH;
    end else begin
        return PORT_NONE;
    end
    if (avail[dir]) return {1'b0, dir};
    if (bc) return PORT_NONE;
    // One step clockwise
    return {1'b0, dir + 2'd1};
endfunction

// Called on a falling edge, returns on a falling edge
task automatic send_msg(input logic [31:0] msg);
    int cycles;
    cycles     = 0;
    in_data_i  = msg;
    in_valid_i = 1'b1;
    @(posedge clk_i);
    while (!in_ready_o && cycles < TIMEOUT) begin
        cycles++;
        @(posedge clk_i);
    end
    if (!in_ready_o) begin
        $display("Timeout: inbound message %h was never accepted", msg);
        timeouts++;
    end
    @(negedge clk_i);
    in_valid_i = 1'b0;
endtask

task automatic expect_out(input logic [2:0] port, input logic [31:0] data);
    int          cycles;
    logic [34:0] got;
    cycles = 0;
    while (seen_q.size() == 0 && cycles < TIMEOUT) begin
        @(negedge clk_i);
        cycles++;
    end
    if (seen_q.size() == 0) begin
        $display("Timeout: message %h never appeared on port %0d", data, port);
        timeouts++;
    end else begin
        got = seen_q.pop_front();
        check_val(got[34:32], port, "output port");
        check_val(got[31:0], data, "output data");
    end
endtask

// Let the pipeline drain, then nothing else may have come out
task automatic expect_quiet();
    repeat (6) @(negedge clk_i);
    check_val(seen_q.size(), 0, "unexpected extra output messages");
    seen_q.delete();
endtask

task automatic route_one(input logic bc, input logic [3:0] row, input logic [3:0] col);
    logic [31:0] payload;
    logic [31:0] msg;
    logic [2:0]  port;
    payload = $random(seed);
    msg     = make_msg(bc, row, col, payload);
    port    = ref_fwd_port(msg, present);
    send_msg(msg);
    // Local copy never leaves after the neighbour copy
    if (ref_is_local(msg)) expect_out(PORT_LOCAL, msg);
    if (port != PORT_NONE) expect_out(port, msg);
    expect_quiet();
endtask

task automatic check_outputs_idle(input logic ready_exp);
    check_val(local_valid_o, 1'b0, "local valid");
    check_val({north_valid_o, east_valid_o, south_valid_o, west_valid_o}, 4'b0,
              "neighbour valids");
    check_val(in_ready_o, ready_exp, "in_ready_o");
endtask

task automatic test_reset();
    rst_n_i = 1'b0;
    repeat (2) begin
        @(negedge clk_i);
        check_outputs_idle(1'b0);
    end
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_outputs_idle(1'b1);
endtask

task automatic test_xy_routing();
    logic [3:0] rows [8];
    logic [3:0] cols [8];
    // Four quadrants, then the four axes
    rows    = '{4'd2, 4'd2, 4'd9, 4'd9, 4'd2, 4'd9, 4'd5, 4'd5};
    cols    = '{4'd2, 4'd9, 4'd2, 4'd9, 4'd5, 4'd5, 4'd2, 4'd9};
    present = 4'hf;
    for (int i = 0; i < 8; i++) begin
        route_one(1'b0, rows[i], cols[i]);
    end
endtask

task automatic test_reroute_drop();
    logic [3:0] rows [4];
    logic [3:0] cols [4];
    // Unicast targets straight north, east, south and west
    rows = '{4'd2, 4'd5, 4'd9, 4'd5};
    cols = '{4'd5, 4'd9, 4'd5, 4'd2};
    for (int d = 0; d < 4; d++) begin
        present    = 4'hf;
        present[d] = 1'b0;
        route_one(1'b0, rows[d], cols[d]);
        route_one(1'b1, 4'd3, {d[1:0], 2'b01});
    end
    present = 4'hf;
endtask

task automatic test_broadcast();
    present = 4'hf;
    for (int d = 0; d < 4; d++) begin
        // Both copies are held off for a few cycles
        local_ready_i = 1'b0;
        nb_ready[d]   = 1'b0;
        fork
            route_one(1'b1, 4'd7, {d[1:0], 2'b10});
            begin
                repeat (4) @(negedge clk_i);
                local_ready_i = 1'b1;
                nb_ready[d]   = 1'b1;
            end
        join
    end
endtask

task automatic test_backpressure();
    logic [31:0] burst [8];
    logic [31:0] payload;
    int          cycles;
    present     = 4'hf;
    nb_ready[1] = 1'b0;
    for (int i = 0; i < 8; i++) begin
        payload  = $random(seed);
        burst[i] = make_msg(1'b0, NODE_ROW, 4'd12, payload);
    end
    fork
        begin
            for (int i = 0; i < 8; i++) send_msg(burst[i]);
        end
        begin
            cycles = 0;
            while (in_ready_o && cycles < TIMEOUT) begin
                @(posedge clk_i);
                cycles++;
            end
            if (in_ready_o) begin
                $display("Timeout: in_ready_o never fell while east was stalled");
                timeouts++;
            end
            repeat (4) @(negedge clk_i);
            nb_ready[1] = 1'b1;
        end
    join
    for (int i = 0; i < 8; i++) expect_out(3'd1, burst[i]);
    expect_quiet();
endtask

initial begin
    rst_n_i       = 1'b0;
    in_data_i     = '0;
    in_valid_i    = 1'b0;
    local_ready_i = 1'b1;
    nb_ready      = 4'hf;
    present       = 4'hf;
    test_reset();
    route_one(1'b0, NODE_ROW, NODE_COL);
    test_xy_routing();
    test_reroute_drop();
    test_broadcast();
    test_backpressure();
    $display("Checks finished with %0d errors, %0d assertion failures and %0d timeouts",
             errors, UUT.u_props.assert_fails, timeouts);
    if (errors == 0 && UUT.u_props.assert_fails == 0 && timeouts == 0) begin
        $display("PASS: all tests");
    end else begin
        $display("FAIL: see errors above");
    end
    $finish;
end

endmodule : tb_nx_node_router

/* files.f */
hw/nx_pkg.sv
hw/nx_stream_skid.sv
hw/nx_msg_decoder.sv
hw/nx_stream_distributor.sv
hw/nx_node_router.sv
sim/nx_router_properties.sv
sim/tb_nx_node_router.sv

/* Bender.yml */
package:
  name: nx_node_router

sources:
  - files:
      - hw/nx_pkg.sv
      - hw/nx_stream_skid.sv
      - hw/nx_msg_decoder.sv
      - hw/nx_stream_distributor.sv
      - hw/nx_node_router.sv
  - target: simulation
    files:
      - sim/nx_router_properties.sv
      - sim/tb_nx_node_router.sv
